/* include/board_params.svh */
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Game colour channel width
`define BOARD_COLORW        4
// Joystick word: 4 directions then 6 buttons
`define BOARD_JOYW          10
// Buttons above this count are held inactive
`define BOARD_BUTTONS       2
// Game side polarity of player inputs
`define BOARD_ACTIVE_LOW    1

`define BOARD_RESET_HOLD    16
// Frames per half period of the LED blink
`define BOARD_BLINK_FRAMES  4

// OSD status word map
`define ST_ROTATE           2:1
`define ST_FLIP             3
`define ST_FM_OFF           4
`define ST_PSG_OFF          5
`define ST_TEST             6
`define ST_PAUSE            7
`define ST_FXLEVEL          9:8
`define ST_SCANLINES        12:10

`endif

/* list.f */
+incdir+include
source/board_pkg.sv
source/board_reset.sv
source/board_inputs.sv
source/board_dip.sv
source/board_led.sv
source/board_video.sv
source/board_top.sv
verif/board_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the board testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module board_tb -f list.f -o board_sim \
    && ./obj_dir/board_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && exit 0 \
    || exit 1

/* source/board_dip.sv */
`timescale 1ns/100ps
`include "board_params.svh"

module board_dip
    import board_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    input  logic        game_pause,
    input  logic        game_test,
    output dip_t        dip,
    output logic        dip_test,
    output logic        dip_pause
);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dip       <= '0;
            dip_test  <= 1'b0;
            dip_pause <= 1'b1;
        end else begin
            dip.rotate     <= status[`ST_ROTATE];
            dip.flip       <= status[`ST_FLIP];
            // OSD bits disable the sound chips, game wants enables
            dip.enable_fm  <= ~status[`ST_FM_OFF];
            dip.enable_psg <= ~status[`ST_PSG_OFF];
            dip.fxlevel    <= status[`ST_FXLEVEL];
            dip.scanlines  <= status[`ST_SCANLINES];
            dip_test       <= status[`ST_TEST] | game_test;
            // Active low toward the core
            dip_pause      <= ~(status[`ST_PAUSE] | game_pause);
        end
    end

endmodule

/* source/board_inputs.sv */
`timescale 1ns/100ps
`include "board_params.svh"

module board_inputs
    import board_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst,
    input  board_in_t board,
    input  key_t      keys,
    input  logic      flip,
    output game_in_t  game,
    output logic      game_pause,
    output logic      game_test,
    output logic      soft_rst
);

    localparam int   JW  = `BOARD_JOYW;
    localparam logic POL = 1'(`BOARD_ACTIVE_LOW);
    // Directions plus the buttons the game reads
    localparam logic [31:0] MASK32   = (32'd1 << (`BOARD_BUTTONS + 4)) - 32'd1;
    localparam logic [JW-1:0] JOY_MASK = MASK32[JW-1:0];

    logic [JW-1:0] joy1_or;
    logic [JW-1:0] joy2_or;
    logic [JW-1:0] joy1_fl;
    logic [JW-1:0] joy2_fl;
    game_in_t      merged;
    logic          pause_l;

    assign joy1_or = (board.joystick1[JW-1:0] | keys.joy1) & JOY_MASK;
    assign joy2_or = (board.joystick2[JW-1:0] | keys.joy2) & JOY_MASK;

    // Flipped screen swaps up/down and left/right
    assign joy1_fl = flip ?
        {joy1_or[JW-1:4], joy1_or[2], joy1_or[3], joy1_or[0], joy1_or[1]} : joy1_or;
    assign joy2_fl = flip ?
        {joy2_or[JW-1:4], joy2_or[2], joy2_or[3], joy2_or[0], joy2_or[1]} : joy2_or;

    always_comb begin
        merged.joy1    = joy1_fl ^ {JW{POL}};
        merged.joy2    = joy2_fl ^ {JW{POL}};
        merged.start   = (board.start | keys.start) ^ {2{POL}};
        merged.coin    = (board.coin | keys.coin) ^ {2{POL}};
        merged.service = keys.service ^ POL;
        merged.test    = keys.test ^ POL;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game       <= game_in_t'({$bits(game_in_t){POL}});
            game_pause <= 1'b0;
            game_test  <= 1'b0;
            soft_rst   <= 1'b0;
            pause_l    <= 1'b0;
        end else begin
            game      <= merged;
            game_test <= keys.test;
            soft_rst  <= keys.reset;
            pause_l   <= keys.pause;
            // Toggle on each press
            if (keys.pause && !pause_l) begin
                game_pause <= ~game_pause;
            end
        end
    end

    // Unused buttons never reach the game as pressed
    a_btn_idle: assert property (
        @(posedge clk_sys) disable iff (rst)
        (game.joy1[JW-1:`BOARD_BUTTONS+4] == {(JW-`BOARD_BUTTONS-4){POL}}) &&
        (game.joy2[JW-1:`BOARD_BUTTONS+4] == {(JW-`BOARD_BUTTONS-4){POL}})
    );

endmodule

/* source/board_led.sv */
`timescale 1ns/100ps
`include "board_params.svh"

module board_led (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       LVBL,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int FRAMES = `BOARD_BLINK_FRAMES;
    localparam int FW     = $clog2(FRAMES + 1);

    logic          lvbl_l;
    logic          frame;
    logic [FW-1:0] frame_cnt;
    logic          blink;

    // Start of vertical blank marks a frame
    assign frame = lvbl_l & ~LVBL;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            blink     <= 1'b0;
            led       <= 1'b0;
        end else begin
            lvbl_l <= LVBL;
            if (!downloading) begin
                frame_cnt <= '0;
                blink     <= 1'b0;
            end else if (frame) begin
                if (frame_cnt == FW'(FRAMES - 1)) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            // OSD first, then download blink, then the game
            led <= osd_shown ? 1'b1 : (downloading ? blink : game_led[0]);
        end
    end

endmodule

/* source/board_pkg.sv */
`include "board_params.svh"

package board_pkg;

    // Keyboard state, already decoded, active high
    typedef struct packed {
        logic [`BOARD_JOYW-1:0] joy1;
        logic [`BOARD_JOYW-1:0] joy2;
        logic [1:0]             start;
        logic [1:0]             coin;
        logic                   service;
        logic                   test;
        logic                   pause;
        logic                   reset;
    } key_t;

    // Board controls, active high
    typedef struct packed {
        logic [15:0] joystick1;
        logic [15:0] joystick2;
        logic [1:0]  start;
        logic [1:0]  coin;
    } board_in_t;

    // Inputs as the game core sees them
    typedef struct packed {
        logic [`BOARD_JOYW-1:0] joy1;
        logic [`BOARD_JOYW-1:0] joy2;
        logic [1:0]             start;
        logic [1:0]             coin;
        logic                   service;
        logic                   test;
    } game_in_t;

    typedef struct packed {
        logic [1:0] rotate;
        logic       flip;
        logic       enable_fm;
        logic       enable_psg;
        logic [1:0] fxlevel;
        logic [2:0] scanlines;
    } dip_t;

    typedef struct packed {
        logic [`BOARD_COLORW-1:0] r;
        logic [`BOARD_COLORW-1:0] g;
        logic [`BOARD_COLORW-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

endpackage

/* source/board_reset.sv */
`timescale 1ns/100ps
`include "board_params.svh"

module board_reset (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic soft_rst,
    output logic game_rst
);

    localparam int HOLD = `BOARD_RESET_HOLD;
    localparam int CW   = $clog2(HOLD + 1);

    logic [CW-1:0] hold_cnt;
    logic          cause;

    assign cause = rst | downloading | soft_rst;

    // Reload while any cause is present, drain afterwards
    always_ff @(posedge clk_sys) begin
        if (cause) begin
            hold_cnt <= CW'(HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign game_rst = cause | (hold_cnt != '0);

    // Game reset outlasts a download by the full hold time
    a_dl_rst: assert property (
        @(posedge clk_sys) $past(downloading, HOLD) |-> game_rst
    );

endmodule

/* source/board_top.sv */
`timescale 1ns/100ps

module board_top
    import board_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    input  key_t        keys,
    input  board_in_t   board,
    input  logic        downloading,
    input  logic        osd_shown,
    input  logic [1:0]  game_led,
    input  logic        pxl_cen,
    input  logic        LHBL,
    input  logic        LVBL,
    input  rgb_t        game_rgb,
    output logic        game_rst,
    output game_in_t    game,
    output dip_t        dip,
    output logic        dip_test,
    output logic        dip_pause,
    output logic        led,
    output rgb8_t       video,
    output logic        video_de
);

    logic soft_rst;
    logic game_pause;
    logic game_test;

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .game_rst    ( game_rst    )
    );

    board_inputs u_inputs (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .board      ( board      ),
        .keys       ( keys       ),
        .flip       ( dip.flip   ),
        .game       ( game       ),
        .game_pause ( game_pause ),
        .game_test  ( game_test  ),
        .soft_rst   ( soft_rst   )
    );

    board_dip u_dip (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .status     ( status     ),
        .game_pause ( game_pause ),
        .game_test  ( game_test  ),
        .dip        ( dip        ),
        .dip_test   ( dip_test   ),
        .dip_pause  ( dip_pause  )
    );

    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .LVBL        ( LVBL        ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

    board_video u_video (
        .clk_sys ( clk_sys  ),
        .rst     ( rst      ),
        .pxl_cen ( pxl_cen  ),
        .LHBL    ( LHBL     ),
        .LVBL    ( LVBL     ),
        .rgb_in  ( game_rgb ),
        .rgb_out ( video    ),
        .de      ( video_de )
    );

endmodule

/* source/board_video.sv */
`timescale 1ns/100ps
`include "board_params.svh"

module board_video
    import board_pkg::*;
(
    input  logic  clk_sys,
    input  logic  rst,
    input  logic  pxl_cen,
    input  logic  LHBL,
    input  logic  LVBL,
    input  rgb_t  rgb_in,
    output rgb8_t rgb_out,
    output logic  de
);

    localparam int CW = `BOARD_COLORW;

    // Repeat the channel from its MSB until 8 bits are filled
    function automatic logic [7:0] extend8(input logic [CW-1:0] a);
        logic [7:0] ext;
        for (int i = 0; i < 8; i++) begin
            ext[7-i] = a[CW-1-(i % CW)];
        end
        return ext;
    endfunction

    rgb8_t wide;

    always_comb begin
        wide.r = extend8(rgb_in.r);
        wide.g = extend8(rgb_in.g);
        wide.b = extend8(rgb_in.b);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rgb_out <= '0;
            de      <= 1'b0;
        end else if (pxl_cen) begin
            rgb_out <= wide;
            de      <= LHBL & LVBL;
        end
    end

    // An accepted pixel keeps its colour in the top bits of each channel
    a_pxl_top: assert property (
        @(posedge clk_sys) pxl_cen && !rst |=>
            {rgb_out.r[7 -: CW], rgb_out.g[7 -: CW], rgb_out.b[7 -: CW]} == $past(rgb_in)
    );

endmodule

/* verif/board_tb.sv */
`timescale 1ns/100ps

module board_tb
    import board_pkg::*;
();

    logic        clk_sys;
    logic        rst;
    logic [31:0] status;
    key_t        keys;
    board_in_t   board;
    logic        downloading;
    logic        osd_shown;
    logic [1:0]  game_led;
    logic        pxl_cen;
    logic        LHBL;
    logic        LVBL;
    rgb_t        game_rgb;
    logic        game_rst;
    game_in_t    game;
    dip_t        dip;
    logic        dip_test;
    logic        dip_pause;
    logic        led;
    rgb8_t       video;
    logic        video_de;

    int    errors = 0;
    int    cycles = 0;
    int    cycle_limit = 0;
    string records[$];

    board_top dut0 (.*);

    always #5 clk_sys = ~clk_sys;

    // Run guard, armed once the test data is loaded
    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: test data not finished after %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic load_records();
        int    fd;
        int    hold;
        int    total;
        string line;
        total = 0;
        fd = $fopen("verif/board_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Records start with their hold count, anything else is skipped
                if (line.len() > 0 && line.getc(0) >= "0" && line.getc(0) <= "9") begin
                    void'($sscanf(line, "%d", hold));
                    total += hold;
                    records.push_back(line);
                end
            end
            $fclose(fd);
        end
        if (records.size() == 0) begin
            $display("No records found in the test data");
            errors++;
        end
        cycle_limit = 2 * total + 100;
    endtask

    task automatic apply_record(input string line);
        int                        n;
        int                        hold;
        logic [31:0]               st;
        logic [$bits(key_t)-1:0]   kv;
        logic [$bits(board_in_t)-1:0] bv;
        logic [31:0]               dl;
        logic [31:0]               osd;
        logic [31:0]               gl;
        logic [31:0]               pc;
        logic [31:0]               hb;
        logic [31:0]               vb;
        logic [31:0]               rgbv;
        logic [31:0]               e_rst;
        logic [31:0]               e_game;
        logic [31:0]               e_dip;
        logic [31:0]               e_test;
        logic [31:0]               e_pause;
        logic [31:0]               e_led;
        logic [31:0]               e_video;
        logic [31:0]               e_de;
        n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    hold, st, kv, bv, dl, osd, gl, pc, hb, vb, rgbv,
                    e_rst, e_game, e_dip, e_test, e_pause, e_led, e_video, e_de);
        if (n != 19) begin
            errors++;
            $display("Malformed record in the test data: %s", line);
        end else begin
            @(posedge clk_sys);
            status      <= st;
            keys        <= key_t'(kv);
            board       <= board_in_t'(bv);
            downloading <= dl[0];
            osd_shown   <= osd[0];
            game_led    <= gl[1:0];
            pxl_cen     <= pc[0];
            LHBL        <= hb[0];
            LVBL        <= vb[0];
            game_rgb    <= rgb_t'(rgbv[$bits(rgb_t)-1:0]);
            repeat (hold) @(posedge clk_sys);
            // Sample away from the active edge
            @(negedge clk_sys);
            compare("game_rst", e_rst, 32'(game_rst));
            compare("game", e_game, 32'(game));
            compare("dip", e_dip, 32'(dip));
            compare("dip_test", e_test, 32'(dip_test));
            compare("dip_pause", e_pause, 32'(dip_pause));
            compare("led", e_led, 32'(led));
            compare("video", e_video, 32'(video));
            compare("video_de", e_de, 32'(video_de));
        end
    endtask

    initial begin
        clk_sys     = 1'b0;
        rst         = 1'b1;
        status      = '0;
        keys        = '0;
        board       = '0;
        downloading = 1'b0;
        osd_shown   = 1'b0;
        game_led    = '0;
        pxl_cen     = 1'b0;
        LHBL        = 1'b0;
        LVBL        = 1'b0;
        game_rgb    = '0;
        load_records();
        repeat (8) @(posedge clk_sys);
        rst <= 1'b0;
        foreach (records[i]) begin
            apply_record(records[i]);
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verif/board_testdata.txt */
# hold status keys board dl osd gled pxl lhbl lvbl rgb | game_rst game dip test pause led video de
# Inputs hold for the given cycles, outputs are checked at the end, all values hex except hold
13 0 0 0 0 0 0 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
1 0 0500080 00C102046 0 0 0 0 0 0 000 0 3EAFEC7 060 0 1 0 000000 0
2 8 0500080 00C102046 0 0 0 0 0 0 000 0 3E5FDC7 0E0 0 1 0 000000 0
2 0 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
2 0 2 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 0 0 000000 0
1 0 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 0 0 000000 0
2 0 2 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
1 80 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 0 0 000000 0
1 40 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 1 1 0 000000 0
2 0 4 0 0 0 0 0 0 0 000 0 3FFFFFE 060 1 1 0 000000 0
2 1714 0 0 0 0 0 0 0 0 000 0 3FFFFFF 23D 0 1 0 000000 0
1 0 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
2 0 1 0 0 0 0 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
16 0 0 0 0 0 0 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
2 0 1 0 0 0 0 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
17 0 0 0 0 0 0 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 0 1 0 0 0 0 000 0 3FFFFFF 060 0 1 1 000000 0
1 0 0 0 0 0 1 0 0 0 000 0 3FFFFFF 060 0 1 1 000000 0
1 0 0 0 0 0 2 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
2 0 0 0 1 0 2 0 0 1 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 1 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 1 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 1 000 1 3FFFFFF 060 0 1 0 000000 0
2 0 0 0 1 0 2 0 0 0 000 1 3FFFFFF 060 0 1 1 000000 0
15 0 0 0 0 0 2 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 1 0 2 0 0 0 000 1 3FFFFFF 060 0 1 0 000000 0
16 0 0 0 0 0 2 0 0 0 000 0 3FFFFFF 060 0 1 0 000000 0
1 0 0 0 0 0 2 1 1 1 A53 0 3FFFFFF 060 0 1 0 AA5533 1
2 0 0 0 0 0 2 0 0 1 1F0 0 3FFFFFF 060 0 1 0 AA5533 1
1 0 0 0 0 0 2 1 1 0 1F0 0 3FFFFFF 060 0 1 0 11FF00 0
1 0 0 0 0 0 2 1 1 1 C69 0 3FFFFFF 060 0 1 0 CC6699 1
